// ==== verilog/imuldiv_pkg.sv ====
/*
 * Shared types for the iterative multiply/divide unit.
 * Referenced by scoped name from the RTL and the testbench.
 */
package imuldiv_pkg;

  // ------------------------------------------------
  // widths
  // ------------------------------------------------

  // operand width, one machine word
  localparam int unsigned XLEN = 32;

  // result width
  // a full product, or remainder and quotient side by side
  localparam int unsigned RLEN = 2 * XLEN;

  // iteration counter width
  // the counter runs once through every value, one step per operand bit
  localparam int unsigned CNT_W = $clog2(XLEN);

  // ------------------------------------------------
  // opcodes
  // ------------------------------------------------

  // FN_MUL goes to the multiplier
  // both divide codes go to the divider
  typedef enum logic [1:0] {
    // signed multiply, full 64-bit product
    FN_MUL  = 2'd0,
    // signed divide, truncates toward zero
    FN_DIV  = 2'd1,
    // unsigned divide
    FN_DIVU = 2'd2
  } imuldiv_fn_e;

  // ------------------------------------------------
  // request and response messages
  // ------------------------------------------------

  // request message, 66 bits
  typedef struct packed {
    imuldiv_fn_e     fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } imuldiv_req_t;

  // response message, 64 bits
  // multiply: signed product
  // divide: remainder in [63:32], quotient in [31:0]
  typedef struct packed {
    logic [RLEN-1:0] result;
  } imuldiv_resp_t;

endpackage

// ==== verilog/imuldiv_mul_dpath.sv ====
/*
 * Shift-and-add multiplier datapath. Driven by the strobes of the
 * multiplier control FSM; the signed product appears on result.
 */
`timescale 1ns/10ps

module imuldiv_mul_dpath (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [imuldiv_pkg::XLEN-1:0]    a,
  input  logic [imuldiv_pkg::XLEN-1:0]    b,
  // a_en: update the a register this cycle
  // a_mux_sel: 0 loads the operand, 1 takes the shifted value
  input  logic                            a_en,
  input  logic                            a_mux_sel,
  input  logic                            b_en,
  input  logic                            b_mux_sel,
  output logic [imuldiv_pkg::RLEN-1:0]    result
);

  // ------------------------------------------------
  // sign stripping
  // ------------------------------------------------

  logic                         sign_a;
  logic                         sign_b;
  logic [imuldiv_pkg::XLEN-1:0] a_mag;
  logic [imuldiv_pkg::XLEN-1:0] b_mag;

  assign sign_a = a[imuldiv_pkg::XLEN-1];
  assign sign_b = b[imuldiv_pkg::XLEN-1];
  // magnitude of the most negative number still fits as unsigned
  assign a_mag  = sign_a ? (~a + 1'b1) : a;
  assign b_mag  = sign_b ? (~b + 1'b1) : b;

  // ------------------------------------------------
  // shift registers and accumulator
  // ------------------------------------------------

  logic [imuldiv_pkg::RLEN-1:0] a_reg;
  logic [imuldiv_pkg::XLEN-1:0] b_reg;
  logic [imuldiv_pkg::RLEN-1:0] acc_reg;
  logic                         sign_a_reg;
  logic                         sign_b_reg;
  logic [imuldiv_pkg::RLEN-1:0] a_mux_out;
  logic [imuldiv_pkg::XLEN-1:0] b_mux_out;
  logic [imuldiv_pkg::RLEN-1:0] acc_next;

  // a magnitude sits in the low half, upper half starts clear
  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{imuldiv_pkg::XLEN{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;
  // add the current a weight when the low bit of b is set
  assign acc_next  = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      acc_reg    <= '0;
    end else if (a_en && !a_mux_sel) begin
      // load cycle, capture signs and clear the sum
      sign_a_reg <= sign_a;
      sign_b_reg <= sign_b;
      acc_reg    <= '0;
    end else if (a_en) begin
      acc_reg <= acc_next;
    end
  end

  // restore the sign when exactly one operand was negative
  assign result = (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 1'b1) : acc_reg;

  // shift select from the control FSM is only meaningful with the enable
  a_sel_needs_en: assert property (@(posedge clk) disable iff (reset)
    a_mux_sel |-> a_en)
    else $error("a_mux_sel high without a_en");

endmodule

// ==== verilog/imuldiv_mul_ctrl.sv ====
/*
 * Multiplier control FSM. Handles the request/response handshake and
 * sequences one load cycle followed by 32 shift-and-add cycles.
 */
`timescale 1ns/10ps

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);

  // ------------------------------------------------
  // state and iteration counter
  // ------------------------------------------------

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e                        state;
  logic [imuldiv_pkg::CNT_W-1:0] count;
  logic                          req_go;
  logic                          resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // all ones marks the 32nd step, so 2^31 magnitudes finish
          if (count == '1) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          // result stays frozen while the consumer stalls
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // handshake and datapath strobes
  // ------------------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    a_mux_sel = 1'b0;
    b_en      = 1'b0;
    b_mux_sel = 1'b0;
    case (state)
      IDLE: begin
        req_rdy = 1'b1;
        // load operands only on the accepting edge
        a_en    = req_go;
        b_en    = req_go;
      end
      CALC: begin
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
      end
      DONE: resp_val = 1'b1;
      default: ;
    endcase
  end

  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("multiplier accepts while holding a response");

endmodule

// ==== verilog/imuldiv_div_iterative.sv ====
/*
 * Iterative restoring divider for signed and unsigned operands.
 * Returns remainder and quotient together after 32 restore steps.
 */
`timescale 1ns/10ps

module imuldiv_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  imuldiv_pkg::imuldiv_fn_e     fn,
  input  logic [imuldiv_pkg::XLEN-1:0] a,
  input  logic [imuldiv_pkg::XLEN-1:0] b,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output logic [imuldiv_pkg::RLEN-1:0] result
);

  localparam int unsigned XLEN = imuldiv_pkg::XLEN;

  // ------------------------------------------------
  // control FSM, same shape as the multiplier
  // ------------------------------------------------

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_e;

  state_e                        state;
  logic [imuldiv_pkg::CNT_W-1:0] count;
  logic                          req_go;
  logic                          resp_go;

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (count == '1) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // operand preparation
  // ------------------------------------------------

  logic            is_signed;
  logic            sign_a;
  logic            sign_b;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  // FN_DIVU treats both operands as plain magnitudes
  assign is_signed = (fn == imuldiv_pkg::FN_DIV);
  assign sign_a    = is_signed && a[XLEN-1];
  assign sign_b    = is_signed && b[XLEN-1];
  assign a_mag     = sign_a ? (~a + 1'b1) : a;
  assign b_mag     = sign_b ? (~b + 1'b1) : b;

  // ------------------------------------------------
  // restoring step
  // ------------------------------------------------

  // rq_reg holds partial remainder above, dividend/quotient bits below
  logic [2*XLEN-1:0] rq_reg;
  logic [XLEN-1:0]   dvsr_reg;
  logic              neg_q_reg;
  logic              neg_r_reg;
  logic              dz_reg;
  logic [XLEN:0]     partial;
  logic [XLEN:0]     diff;
  logic              fits;

  // 33 bits, shifted remainder can exceed a word for large divisors
  assign partial = rq_reg[2*XLEN-1:XLEN-1];
  assign fits    = (partial >= {1'b0, dvsr_reg});
  assign diff    = partial - {1'b0, dvsr_reg};

  always_ff @(posedge clk) begin
    if (req_go) begin
      rq_reg    <= {{XLEN{1'b0}}, a_mag};
      dvsr_reg  <= b_mag;
      neg_q_reg <= sign_a ^ sign_b;
      // remainder follows the dividend
      neg_r_reg <= sign_a;
      dz_reg    <= (b == '0);
    end else if (state == CALC) begin
      // keep the difference only when the divisor fits
      rq_reg <= {fits ? diff[XLEN-1:0] : partial[XLEN-1:0], rq_reg[XLEN-2:0], fits};
    end
  end

  // ------------------------------------------------
  // sign restore and special cases
  // ------------------------------------------------

  logic [XLEN-1:0] quot;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] quot_fix;
  logic [XLEN-1:0] rem_fix;

  assign quot = rq_reg[XLEN-1:0];
  assign rem  = rq_reg[2*XLEN-1:XLEN];

  // divide by zero leaves the dividend magnitude in the remainder,
  // so only the quotient needs overriding to all ones.
  // most negative / -1 wraps back to itself with no extra logic
  assign quot_fix = dz_reg ? '1 : (neg_q_reg ? (~quot + 1'b1) : quot);
  assign rem_fix  = neg_r_reg ? (~rem + 1'b1) : rem;
  assign result   = {rem_fix, quot_fix};

  // top level must never route a multiply here
  no_mul_opcode: assert property (@(posedge clk) disable iff (reset)
    req_go |-> (fn != imuldiv_pkg::FN_MUL))
    else $error("divider accepted a multiply request");

endmodule

// ==== verilog/imuldiv_unit.sv ====
/*
 * Top level of the multiply/divide unit. Steers each request by opcode
 * and merges the multiplier and divider response paths.
 */
`timescale 1ns/10ps

module imuldiv_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // ------------------------------------------------
  // request steering
  // ------------------------------------------------

  logic                         mul_req_val;
  logic                         mul_req_rdy;
  logic                         mul_resp_val;
  logic [imuldiv_pkg::RLEN-1:0] mul_result;
  logic                         div_req_val;
  logic                         div_req_rdy;
  logic                         div_resp_val;
  logic [imuldiv_pkg::RLEN-1:0] div_result;
  logic                         is_mul;
  logic                         a_en;
  logic                         a_mux_sel;
  logic                         b_en;
  logic                         b_mux_sel;

  // only accept when both units are idle, one op in flight
  assign req_rdy     = mul_req_rdy && div_req_rdy;
  assign is_mul      = (req.fn == imuldiv_pkg::FN_MUL);
  assign mul_req_val = req_val && req_rdy && is_mul;
  assign div_req_val = req_val && req_rdy && !is_mul;

  // ------------------------------------------------
  // units
  // ------------------------------------------------

  imuldiv_mul_ctrl u_mul_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (mul_req_val),
    .req_rdy   (mul_req_rdy),
    .resp_val  (mul_resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

  imuldiv_mul_dpath u_mul_dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result    (mul_result)
  );

  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .fn       (req.fn),
    .a        (req.a),
    .b        (req.b),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .result   (div_result)
  );

  // response merge, no extra register stage
  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp.result = mul_resp_val ? mul_result : div_result;

  one_resp_source: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val))
    else $error("multiplier and divider responding together");

endmodule

// ==== verification/imuldiv_unit_tb.sv ====
/*
 * Testbench for the multiply/divide unit. Applies a table of directed and
 * LCG-generated requests, checks results, latency and back-pressure behavior.
 */
`timescale 1ns/10ps

module imuldiv_unit_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_DIRECTED = 20;
  localparam int NUM_VEC      = NUM_DIRECTED + 200;
  localparam int MAX_STALL    = 5;
  localparam int LATENCY      = 33;
  // give up on a response a few cycles past the fixed latency
  localparam int LAT_LIMIT    = LATENCY + 8;
  localparam int WATCHDOG_NS  =
    (NUM_VEC * (LATENCY + MAX_STALL + 4) + RESET_CYCLES) * CLK_PERIOD;

  // one table row holds a request and how long the consumer stalls
  typedef struct packed {
    imuldiv_pkg::imuldiv_req_t req;
    logic [2:0]                stall;
  } vec_t;

  logic                       clk;
  logic                       reset;
  imuldiv_pkg::imuldiv_req_t  req;
  logic                       req_val;
  logic                       req_rdy;
  imuldiv_pkg::imuldiv_resp_t resp;
  logic                       resp_val;
  logic                       resp_rdy;
  vec_t                       vectors [NUM_VEC];

  imuldiv_unit i_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_resp(input imuldiv_pkg::imuldiv_resp_t got,
                            input imuldiv_pkg::imuldiv_resp_t exp, input string what);
    if (got !== exp)
      stop_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                         $time, what, got.result, exp.result));
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("MISMATCH at %0t ns: latency got %0d cycles expected %0d",
                         $time, got, exp));
  endtask

  // single-bit handshake levels
  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                         $time, what, got, exp));
  endtask

  // fires far past the longest legal test when something is stuck
  initial begin
    #(WATCHDOG_NS);
    stop_run("timeout: the test did not finish in the allowed time");
  end

  // --------------------------------------------------
  // reference model and table setup
  // --------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic vec_t make_vec(input imuldiv_pkg::imuldiv_fn_e fn,
                                    input logic [31:0] a, input logic [31:0] b,
                                    input logic [2:0] stall);
    vec_t v;
    v.req.fn = fn;
    v.req.a  = a;
    v.req.b  = b;
    v.stall  = stall;
    return v;
  endfunction

  function automatic imuldiv_pkg::imuldiv_resp_t model_result(
      input imuldiv_pkg::imuldiv_req_t r);
    imuldiv_pkg::imuldiv_resp_t exp;
    logic signed [63:0]         prod;
    logic [31:0]                q;
    logic [31:0]                rem;
    prod = $signed({{32{r.a[31]}}, r.a}) * $signed({{32{r.b[31]}}, r.b});
    if (r.b == '0) begin
      // divide by zero gives an all ones quotient and the dividend as remainder
      q   = '1;
      rem = r.a;
    end else if (r.fn == imuldiv_pkg::FN_DIV && r.a == 32'h8000_0000 && r.b == '1) begin
      // overflow case wraps back to the dividend
      q   = r.a;
      rem = '0;
    end else if (r.fn == imuldiv_pkg::FN_DIV) begin
      // signed divide truncates toward zero and the remainder follows the dividend
      q   = $signed(r.a) / $signed(r.b);
      rem = $signed(r.a) % $signed(r.b);
    end else begin
      q   = r.a / r.b;
      rem = r.a % r.b;
    end
    exp.result = (r.fn == imuldiv_pkg::FN_MUL) ? prod : {rem, q};
    return exp;
  endfunction

  task automatic load_table();
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    imuldiv_pkg::imuldiv_fn_e fn;
    logic [2:0] stall;
    // multiply corners
    vectors[0]  = make_vec(imuldiv_pkg::FN_MUL,  32'h0000_0000, 32'h0000_0000, 3'd0);
    vectors[1]  = make_vec(imuldiv_pkg::FN_MUL,  32'h0000_0001, 32'h0000_0001, 3'd1);
    vectors[2]  = make_vec(imuldiv_pkg::FN_MUL,  32'hffff_ffff, 32'hffff_ffff, 3'd0);
    vectors[3]  = make_vec(imuldiv_pkg::FN_MUL,  32'hffff_ffff, 32'h0000_0001, 3'd2);
    vectors[4]  = make_vec(imuldiv_pkg::FN_MUL,  32'h7fff_ffff, 32'h7fff_ffff, 3'd0);
    vectors[5]  = make_vec(imuldiv_pkg::FN_MUL,  32'h8000_0000, 32'h8000_0000, 3'd3);
    vectors[6]  = make_vec(imuldiv_pkg::FN_MUL,  32'h8000_0000, 32'hffff_ffff, 3'd0);
    vectors[7]  = make_vec(imuldiv_pkg::FN_MUL,  32'h1234_5678, 32'hfedc_ba98, 3'd5);
    vectors[8]  = make_vec(imuldiv_pkg::FN_MUL,  32'hffff_fffd, 32'h0000_0005, 3'd0);
    // signed divide over every sign combination
    vectors[9]  = make_vec(imuldiv_pkg::FN_DIV,  32'h0000_0007, 32'h0000_0002, 3'd0);
    vectors[10] = make_vec(imuldiv_pkg::FN_DIV,  32'hffff_fff9, 32'h0000_0002, 3'd1);
    vectors[11] = make_vec(imuldiv_pkg::FN_DIV,  32'h0000_0007, 32'hffff_fffe, 3'd0);
    vectors[12] = make_vec(imuldiv_pkg::FN_DIV,  32'hffff_fff9, 32'hffff_fffe, 3'd4);
    vectors[13] = make_vec(imuldiv_pkg::FN_DIV,  32'h8000_0000, 32'hffff_ffff, 3'd0);
    vectors[14] = make_vec(imuldiv_pkg::FN_DIV,  32'h0000_0005, 32'h0000_0000, 3'd2);
    vectors[15] = make_vec(imuldiv_pkg::FN_DIV,  32'hffff_fff9, 32'h0000_0000, 3'd0);
    // unsigned divide with bit 31 set
    vectors[16] = make_vec(imuldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'h0000_0002, 3'd0);
    vectors[17] = make_vec(imuldiv_pkg::FN_DIVU, 32'h8000_0000, 32'hffff_ffff, 3'd1);
    vectors[18] = make_vec(imuldiv_pkg::FN_DIVU, 32'hffff_fff0, 32'h0001_0000, 3'd0);
    vectors[19] = make_vec(imuldiv_pkg::FN_DIVU, 32'h1234_5678, 32'h0000_0000, 3'd5);
    rnd = 32'd24;
    for (int i = NUM_DIRECTED; i < NUM_VEC; i++) begin
      rnd   = lcg_next(rnd);
      fn    = imuldiv_pkg::imuldiv_fn_e'(2'((rnd >> 16) % 3));
      rnd   = lcg_next(rnd);
      a     = rnd;
      rnd   = lcg_next(rnd);
      b     = rnd;
      // small divisors half the time so quotients use many bits
      if (b[3])
        b = b >> 24;
      rnd   = lcg_next(rnd);
      stall = 3'((rnd >> 16) % (MAX_STALL + 1));
      vectors[i] = make_vec(fn, a, b, stall);
    end
  endtask

  // --------------------------------------------------
  // one request/response transaction
  // --------------------------------------------------

  // entered on a falling edge with req_rdy already high
  task automatic apply_vector(input vec_t v);
    imuldiv_pkg::imuldiv_resp_t expected;
    int cycles;
    expected = model_result(v.req);
    req      = v.req;
    req_val  = 1'b1;
    resp_rdy = 1'b0;
    @(posedge clk);
    @(negedge clk);
    req_val = 1'b0;
    // the accepting edge counts as the first
    cycles  = 1;
    while (!resp_val && cycles < LAT_LIMIT) begin
      check_flag(req_rdy, 1'b0, "req_rdy while busy");
      @(negedge clk);
      cycles++;
    end
    check_latency(cycles, LATENCY);
    check_flag(req_rdy, 1'b0, "req_rdy with response pending");
    check_resp(resp, expected, "result");
    repeat (v.stall) begin
      // offer another request that has to be refused
      req.a   = ~req.a;
      req.b   = ~req.b;
      req_val = 1'b1;
      @(negedge clk);
      check_flag(resp_val, 1'b1, "resp_val during stall");
      check_flag(req_rdy, 1'b0, "req_rdy during stall");
      check_resp(resp, expected, "held result");
    end
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    check_flag(resp_val, 1'b0, "resp_val after handshake");
    check_flag(req_rdy, 1'b1, "req_rdy after handshake");
  endtask

  initial begin
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag(req_rdy, 1'b1, "req_rdy after reset");
    check_flag(resp_val, 1'b0, "resp_val after reset");
    for (int i = 0; i < NUM_VEC; i++)
      apply_vector(vectors[i]);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== imuldiv_unit.f ====
verilog/imuldiv_pkg.sv
verilog/imuldiv_mul_dpath.sv
verilog/imuldiv_mul_ctrl.sv
verilog/imuldiv_div_iterative.sv
verilog/imuldiv_unit.sv
verification/imuldiv_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the multiply/divide unit testbench.
# Override any variable on the command line, e.g. make run BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= imuldiv_unit_tb
FLIST     ?= imuldiv_unit.f
BUILD_DIR ?= build
VFLAGS    ?= --assert -j 0

# sources are every non-option line of the file list
SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulator is the pass/fail result
run: $(BIN)
	$(BIN)

clean:
	rm -rf $(BUILD_DIR)
